// File: source/mm_pkg.sv
/*
 * Shared widths and enums for the matrix-multiply accelerator.
 * Every RTL module pulls these in with a wildcard import.
 */
package mm_pkg;

    // one signed matrix element
    localparam int ELEM_W = 8;
    // accumulator and result word
    localparam int ACC_W = 32;
    // memory port, byte addressed
    localparam int MEM_AW = 32;
    localparam int MEM_DW = 32;

    // apb register map, word index = paddr[4:2]
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_STATUS = 3'd1,
        REG_A_ADDR = 3'd2,
        REG_B_ADDR = 3'd3,
        REG_C_ADDR = 3'd4
    } mm_reg_e;

    // dma sequencing
    typedef enum logic [2:0] {
        IDLE,
        FETCH_A,
        FETCH_B,
        COMPUTE,
        WRITE_C
    } dma_state_e;

endpackage

// File: source/mm_apb_regs.sv
/*
 * APB register block of the accelerator. Holds the A, B and C base
 * addresses and the sticky done bit, and turns a CTRL write into a start.
 */
module mm_apb_regs
    import mm_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [31:0]       paddr_i,
    input  logic [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    input  logic              busy_i,
    input  logic              done_i,
    output logic              start_o,
    output logic [MEM_AW-1:0] a_addr_o,
    output logic [MEM_AW-1:0] b_addr_o,
    output logic [MEM_AW-1:0] c_addr_o,
    output logic              irq_o
);

    mm_reg_e reg_idx;
    logic    mapped;
    logic    access;
    logic    wr_en;
    logic    done_q;

    assign reg_idx = mm_reg_e'(paddr_i[4:2]);
    // word aligned, inside the five-register window
    assign mapped = (paddr_i[31:5] == '0) && (paddr_i[1:0] == 2'b00) &&
                    (paddr_i[4:2] <= REG_C_ADDR);
    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i && mapped;

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;
    assign irq_o     = done_i;

    // read mux, ctrl is write-only
    always_comb begin
        prdata_o = '0;
        if (mapped) begin
            case (reg_idx)
                REG_STATUS: prdata_o = {30'd0, done_q, busy_i};
                REG_A_ADDR: prdata_o = a_addr_o;
                REG_B_ADDR: prdata_o = b_addr_o;
                REG_C_ADDR: prdata_o = c_addr_o;
                default:    prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_o  <= 1'b0;
            done_q   <= 1'b0;
            a_addr_o <= '0;
            b_addr_o <= '0;
            c_addr_o <= '0;
        end else begin
            // one-cycle start, dropped while a job runs
            start_o <= wr_en && (reg_idx == REG_CTRL) && pwdata_i[0] && !busy_i;
            // done sticks until any status write
            if (done_i) begin
                done_q <= 1'b1;
            end else if (wr_en && (reg_idx == REG_STATUS)) begin
                done_q <= 1'b0;
            end
            if (wr_en) begin
                case (reg_idx)
                    REG_A_ADDR: a_addr_o <= pwdata_i;
                    REG_B_ADDR: b_addr_o <= pwdata_i;
                    REG_C_ADDR: c_addr_o <= pwdata_i;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: source/mm_dma_engine.sv
/*
 * DMA engine and sequencer. Reads the rows of A and B into local buffers,
 * feeds them to the systolic array one k per cycle, then writes the
 * captured accumulators back to C in row-major order.
 */
module mm_dma_engine
    import mm_pkg::*;
#(
    parameter int SA_WIDTH = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start_i,
    input  logic [MEM_AW-1:0]                   a_addr_i,
    input  logic [MEM_AW-1:0]                   b_addr_i,
    input  logic [MEM_AW-1:0]                   c_addr_i,
    output logic                                mem_req_o,
    output logic                                mem_we_o,
    output logic [MEM_AW-1:0]                   mem_addr_o,
    output logic [MEM_DW-1:0]                   mem_wdata_o,
    input  logic                                mem_gnt_i,
    input  logic                                mem_rvalid_i,
    input  logic [MEM_DW-1:0]                   mem_rdata_i,
    output logic                                busy_o,
    output logic                                done_o,
    output logic                                clear_o,
    output logic                                feed_valid_o,
    output logic [SA_WIDTH*ELEM_W-1:0]          a_col_o,
    output logic [SA_WIDTH*ELEM_W-1:0]          b_row_o,
    input  logic [SA_WIDTH*SA_WIDTH*ACC_W-1:0]  acc_flat_i,
    input  logic                                result_valid_i
);

    localparam int ROW_W = SA_WIDTH * ELEM_W;
    localparam int NUM_C = SA_WIDTH * SA_WIDTH;
    // counts rows, compute steps and result words
    localparam int CNT_W = $clog2(NUM_C + SA_WIDTH);
    localparam int K_W   = $clog2(SA_WIDTH);

    dma_state_e          state_q;
    logic [CNT_W-1:0]    cnt_q;
    logic                rd_pend_q;
    logic [MEM_DW-1:0]   a_buf [SA_WIDTH];
    logic [MEM_DW-1:0]   b_buf [SA_WIDTH];
    logic [NUM_C*ACC_W-1:0] c_buf;
    logic [K_W-1:0]      k;
    logic [MEM_AW-1:0]   cnt_off;
    logic                last_row;
    logic                issue_rd;
    logic                issue_wr;
    logic                rd_done;
    logic                capture;

    assign cnt_off  = MEM_AW'({cnt_q, 2'b00});
    assign last_row = (cnt_q == CNT_W'(SA_WIDTH - 1));
    // one read in flight at most
    assign issue_rd = (state_q inside {FETCH_A, FETCH_B}) && !mem_req_o && !rd_pend_q;
    assign issue_wr = (state_q == WRITE_C) && !mem_req_o;
    assign rd_done  = rd_pend_q && mem_rvalid_i;
    assign capture  = (state_q == COMPUTE) && (cnt_q == CNT_W'(SA_WIDTH + 1)) &&
                      result_valid_i;

    assign busy_o = (state_q != IDLE);

    // compute phase: cnt 0 clears, 1..SA_WIDTH feed k = cnt-1, then wait
    assign clear_o      = (state_q == COMPUTE) && (cnt_q == '0);
    assign feed_valid_o = (state_q == COMPUTE) && (cnt_q != '0) &&
                          (cnt_q <= CNT_W'(SA_WIDTH));
    assign k = K_W'(cnt_q - 1'b1);

    // column k of A is byte k of every A row
    always_comb begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            a_col_o[i*ELEM_W +: ELEM_W] = a_buf[i][k*ELEM_W +: ELEM_W];
        end
        b_row_o = b_buf[k][ROW_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            rd_pend_q <= 1'b0;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= FETCH_A;
                        cnt_q   <= '0;
                    end
                end
                FETCH_A, FETCH_B: begin
                    if (issue_rd) begin
                        mem_req_o <= 1'b1;
                        mem_we_o  <= 1'b0;
                    end else if (mem_req_o && mem_gnt_i) begin
                        mem_req_o <= 1'b0;
                        rd_pend_q <= 1'b1;
                    end else if (rd_done) begin
                        rd_pend_q <= 1'b0;
                        cnt_q     <= last_row ? '0 : cnt_q + 1'b1;
                        if (last_row) begin
                            state_q <= (state_q == FETCH_A) ? FETCH_B : COMPUTE;
                        end
                    end
                end
                COMPUTE: begin
                    if (cnt_q != CNT_W'(SA_WIDTH + 1)) begin
                        cnt_q <= cnt_q + 1'b1;
                    end else if (result_valid_i) begin
                        state_q <= WRITE_C;
                        cnt_q   <= '0;
                    end
                end
                WRITE_C: begin
                    if (issue_wr) begin
                        mem_req_o <= 1'b1;
                        mem_we_o  <= 1'b1;
                    end else if (mem_gnt_i) begin
                        mem_req_o <= 1'b0;
                        mem_we_o  <= 1'b0;
                        // last word granted, job ends next cycle
                        if (cnt_q == CNT_W'(NUM_C - 1)) begin
                            state_q <= IDLE;
                            cnt_q   <= '0;
                            done_o  <= 1'b1;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // row buffers, result snapshot and request payload
    always_ff @(posedge clk) begin
        if (rd_done) begin
            if (state_q == FETCH_A) begin
                a_buf[cnt_q[K_W-1:0]] <= mem_rdata_i;
            end else begin
                b_buf[cnt_q[K_W-1:0]] <= mem_rdata_i;
            end
        end
        if (capture) begin
            c_buf <= acc_flat_i;
        end
        if (issue_rd) begin
            mem_addr_o <= ((state_q == FETCH_A) ? a_addr_i : b_addr_i) + cnt_off;
        end
        if (issue_wr) begin
            mem_addr_o  <= c_addr_i + cnt_off;
            mem_wdata_o <= c_buf[cnt_q*ACC_W +: ACC_W];
        end
    end

endmodule

// File: source/mm_systolic_array.sv
/*
 * Output-stationary systolic array. A enters from the left and B from the
 * top, each skewed by its lane index; every cell keeps its own sum.
 */
module mm_systolic_array
    import mm_pkg::*;
#(
    parameter int SA_WIDTH = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               clear_i,
    input  logic                               feed_valid_i,
    input  logic [SA_WIDTH*ELEM_W-1:0]         a_col_i,
    input  logic [SA_WIDTH*ELEM_W-1:0]         b_row_i,
    output logic [SA_WIDTH*SA_WIDTH*ACC_W-1:0] acc_flat_o,
    output logic                               result_valid_o
);

    // last operand reaches cell (n-1,n-1) after this many cycles
    localparam int DEPTH = 2 * SA_WIDTH - 1;

    logic signed [ELEM_W-1:0] a_edge [SA_WIDTH];
    logic signed [ELEM_W-1:0] b_edge [SA_WIDTH];
    logic signed [ELEM_W-1:0] a_q    [SA_WIDTH][SA_WIDTH];
    logic signed [ELEM_W-1:0] b_q    [SA_WIDTH][SA_WIDTH];
    logic signed [ACC_W-1:0]  acc_q  [SA_WIDTH][SA_WIDTH];
    logic [DEPTH-1:0]         vld_sr;

    for (genvar i = 0; i < SA_WIDTH; i++) begin : g_skew
        logic signed [ELEM_W-1:0] a_in;
        logic signed [ELEM_W-1:0] b_in;

        // idle cycles push zeros so sums stay put
        assign a_in = feed_valid_i ? a_col_i[i*ELEM_W +: ELEM_W] : '0;
        assign b_in = feed_valid_i ? b_row_i[i*ELEM_W +: ELEM_W] : '0;

        if (i == 0) begin : g_direct
            assign a_edge[i] = a_in;
            assign b_edge[i] = b_in;
        end else begin : g_delay
            // lane i waits i cycles
            logic signed [ELEM_W-1:0] a_dly [i];
            logic signed [ELEM_W-1:0] b_dly [i];

            always_ff @(posedge clk) begin
                if (clear_i) begin
                    for (int d = 0; d < i; d++) begin
                        a_dly[d] <= '0;
                        b_dly[d] <= '0;
                    end
                end else begin
                    a_dly[0] <= a_in;
                    b_dly[0] <= b_in;
                    for (int d = 1; d < i; d++) begin
                        a_dly[d] <= a_dly[d-1];
                        b_dly[d] <= b_dly[d-1];
                    end
                end
            end
            assign a_edge[i] = a_dly[i-1];
            assign b_edge[i] = b_dly[i-1];
        end
    end

    for (genvar i = 0; i < SA_WIDTH; i++) begin : g_row
        for (genvar j = 0; j < SA_WIDTH; j++) begin : g_col
            logic signed [ELEM_W-1:0]   a_op;
            logic signed [ELEM_W-1:0]   b_op;
            logic signed [2*ELEM_W-1:0] prod;

            // a from the left neighbour, b from above
            if (j == 0) begin : g_a_edge
                assign a_op = a_edge[i];
            end else begin : g_a_pass
                assign a_op = a_q[i][j-1];
            end
            if (i == 0) begin : g_b_edge
                assign b_op = b_edge[j];
            end else begin : g_b_pass
                assign b_op = b_q[i-1][j];
            end

            assign prod = a_op * b_op;

            always_ff @(posedge clk) begin
                if (clear_i) begin
                    a_q[i][j]   <= '0;
                    b_q[i][j]   <= '0;
                    acc_q[i][j] <= '0;
                end else begin
                    a_q[i][j]   <= a_op;
                    b_q[i][j]   <= b_op;
                    acc_q[i][j] <= acc_q[i][j] + prod;
                end
            end

            assign acc_flat_o[(i*SA_WIDTH+j)*ACC_W +: ACC_W] = acc_q[i][j];
        end
    end

    // feed_valid delayed by DEPTH, flagged on its falling edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[DEPTH-2:0], feed_valid_i};
        end
    end

    assign result_valid_o = vld_sr[DEPTH-1] && !vld_sr[DEPTH-2];

endmodule

// File: source/mm_accel_top.sv
/*
 * Top of the matrix-multiply accelerator. APB slave for the host and one
 * request/grant memory master; raises irq_o when a job completes.
 */
module mm_accel_top
    import mm_pkg::*;
#(
    parameter int SA_WIDTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [31:0]       paddr_i,
    input  logic [31:0]       pwdata_i,
    output logic [31:0]       prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output logic [MEM_AW-1:0] mem_addr_o,
    output logic [MEM_DW-1:0] mem_wdata_o,
    input  logic              mem_gnt_i,
    input  logic              mem_rvalid_i,
    input  logic [MEM_DW-1:0] mem_rdata_i,
    output logic              irq_o
);

    // register block <-> dma
    logic              start_pulse;
    logic              busy;
    logic              done_pulse;
    logic [MEM_AW-1:0] a_addr;
    logic [MEM_AW-1:0] b_addr;
    logic [MEM_AW-1:0] c_addr;

    // dma <-> array
    logic                               clear;
    logic                               feed_valid;
    logic [SA_WIDTH*ELEM_W-1:0]         a_col;
    logic [SA_WIDTH*ELEM_W-1:0]         b_row;
    logic [SA_WIDTH*SA_WIDTH*ACC_W-1:0] acc_flat;
    logic                               result_valid;

    mm_apb_regs i_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .busy_i    (busy),
        .done_i    (done_pulse),
        .start_o   (start_pulse),
        .a_addr_o  (a_addr),
        .b_addr_o  (b_addr),
        .c_addr_o  (c_addr),
        .irq_o     (irq_o)
    );

    mm_dma_engine #(.SA_WIDTH(SA_WIDTH)) i_dma (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_pulse),
        .a_addr_i       (a_addr),
        .b_addr_i       (b_addr),
        .c_addr_i       (c_addr),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_gnt_i      (mem_gnt_i),
        .mem_rvalid_i   (mem_rvalid_i),
        .mem_rdata_i    (mem_rdata_i),
        .busy_o         (busy),
        .done_o         (done_pulse),
        .clear_o        (clear),
        .feed_valid_o   (feed_valid),
        .a_col_o        (a_col),
        .b_row_o        (b_row),
        .acc_flat_i     (acc_flat),
        .result_valid_i (result_valid)
    );

    mm_systolic_array #(.SA_WIDTH(SA_WIDTH)) i_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_i        (clear),
        .feed_valid_i   (feed_valid),
        .a_col_i        (a_col),
        .b_row_i        (b_row),
        .acc_flat_o     (acc_flat),
        .result_valid_o (result_valid)
    );

endmodule

// File: dv/mm_accel_properties.sv
/*
 * Concurrent checks on the APB and memory ports of the accelerator top.
 * Bound into every mm_accel_top instance.
 */
module mm_accel_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pready_o,
    input logic        mem_req_o,
    input logic        mem_we_o,
    input logic [31:0] mem_addr_o,
    input logic [31:0] mem_wdata_o,
    input logic        mem_gnt_i,
    input logic        mem_rvalid_i,
    input logic        irq_o,
    input logic        busy,
    input logic        start_pulse
);

    // a granted read waiting for its data beat
    logic rd_out;

    // failed assertions so far
    int unsigned fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_out <= 1'b0;
        end else if (mem_req_o && !mem_we_o && mem_gnt_i) begin
            rd_out <= 1'b1;
        end else if (mem_rvalid_i) begin
            rd_out <= 1'b0;
        end
    end

    // request payload held until grant
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) &&
            $stable(mem_addr_o) && $stable(mem_wdata_o))
        else begin
            fail_count++;
            $error("memory request changed before grant");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        psel_i && penable_i |-> pready_o)
        else begin
            fail_count++;
            $error("pready_o low in access phase");
        end

    assert property (@(posedge clk) disable iff (!rst_n) irq_o |=> !irq_o)
        else begin
            fail_count++;
            $error("irq_o held longer than one cycle");
        end

    assert property (@(posedge clk) disable iff (!rst_n) rd_out |-> !mem_req_o)
        else begin
            fail_count++;
            $error("request issued while a read is outstanding");
        end

    assert property (@(posedge clk)
        !rst_n |-> !mem_req_o && !irq_o && !busy && !start_pulse)
        else begin
            fail_count++;
            $error("control output active during reset");
        end

endmodule

bind mm_accel_top mm_accel_properties i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pready_o     (pready_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .irq_o        (irq_o),
    .busy         (busy),
    .start_pulse  (start_pulse)
);

// File: dv/mm_accel_tb.sv
/*
 * Testbench for the matrix-multiply accelerator. Drives APB, models a
 * request/grant memory with random delays and compares C with a reference.
 */
module mm_accel_tb;

    localparam int N     = 4;
    localparam int LIMIT = 3 * (2 * 16 + 11 + 16) * 4 + 300;

    logic        clk;
    logic        rst_n;
    logic        psel_i, penable_i, pwrite_i;
    logic [31:0] paddr_i, pwdata_i, prdata_o;
    logic        pready_o, pslverr_o;
    logic        mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
    logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
    logic        irq_o;

    integer             seed = 32'hb0c8_202e;
    logic [31:0]        mem     [256];
    logic [31:0]        exp_mem [256];
    logic signed [7:0]  a_m [N][N];
    logic signed [7:0]  b_m [N][N];
    int                 txn_count, irq_count, cycles, gnt_left, rd_left;
    logic               req_seen;
    logic [7:0]         rd_idx;
    logic [31:0]        rd_data;
    logic               rd_err;

    mm_accel_top #(.SA_WIDTH(N)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Errors found");
        $fatal(1, "value mismatch");
    endtask

    // memory model, grant and read data after 0..3 random cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (irq_o) irq_count <= irq_count + 1;
        if (!rst_n) begin
            mem_gnt_i    <= 1'b0;
            mem_rvalid_i <= 1'b0;
            req_seen = 1'b0;
            rd_left  = -1;
        end else begin
            mem_rvalid_i <= 1'b0;
            if (rd_left == 0) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= mem[rd_idx];
                rd_left = -1;
            end else if (rd_left > 0) begin
                rd_left--;
            end
            if (mem_gnt_i) begin
                // grant consumed at this edge
                mem_gnt_i <= 1'b0;
                req_seen = 1'b0;
                txn_count <= txn_count + 1;
                if (mem_we_o) begin
                    mem[mem_addr_o[9:2]] = mem_wdata_o;
                end else begin
                    rd_idx  = mem_addr_o[9:2];
                    rd_left = $random(seed) & 3;
                end
            end else if (mem_req_o) begin
                if (!req_seen) begin
                    req_seen = 1'b1;
                    gnt_left = $random(seed) & 3;
                end
                if (gnt_left == 0) mem_gnt_i <= 1'b1;
                else gnt_left--;
            end
        end
    end

    always @(posedge clk) begin
        if (cycles > LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("Errors found");
            $fatal(1, "timeout");
        end else if (i_dut.i_props.fail_count != 0) begin
            $display("a bound port assertion failed");
            $display("Errors found");
            $fatal(1, "assertion failure");
        end
    end

    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        @(posedge clk);
        // access phase values, sampled before this edge settles
        rdata = prdata_o;
        err   = pslverr_o;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp);
        apb_access(1'b0, addr, '0, rd_data, rd_err);
        assert (rd_data == exp) else report_mismatch("prdata_o", rd_data, exp);
        assert (!rd_err) else report_mismatch("pslverr_o", rd_err, 0);
    endtask

    // extremes alternate -128 and 127, otherwise random bytes
    task automatic load_job(input int a_base, input int b_base, input int c_base,
                            input bit extreme);
        logic [31:0] w;
        for (int i = 0; i < 256; i++) mem[i] = {~i[15:0], i[15:0]} ^ 32'h5a00_00a5;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_m[r][c] = extreme ? (((r + c) % 2) ? 8'sd127 : -8'sd128) : $random(seed);
                b_m[r][c] = extreme ? (((r * c) % 2) ? -8'sd128 : 8'sd127) : $random(seed);
            end
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w[c*8 +: 8] = a_m[r][c];
            end
            mem[a_base/4 + r] = w;
            for (int c = 0; c < N; c++) begin
                w[c*8 +: 8] = b_m[r][c];
            end
            mem[b_base/4 + r] = w;
        end
        exp_mem = mem;
        // reference product, row-major at C
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w = 0;
                for (int k = 0; k < N; k++) w = w + int'(a_m[r][k]) * int'(b_m[k][c]);
                exp_mem[c_base/4 + r*N + c] = w;
            end
        end
        apb_access(1'b1, 32'h08, a_base, rd_data, rd_err);
        apb_access(1'b1, 32'h0c, b_base, rd_data, rd_err);
        apb_access(1'b1, 32'h10, c_base, rd_data, rd_err);
    endtask

    task automatic run_job(input bit restart_while_busy);
        int txn_before;
        int irq_before;
        txn_before = txn_count;
        irq_before = irq_count;
        apb_access(1'b1, 32'h00, 32'h1, rd_data, rd_err);
        expect_read(32'h04, 32'h1);
        if (restart_while_busy) apb_access(1'b1, 32'h00, 32'h1, rd_data, rd_err);
        while (!irq_o) @(posedge clk);
        repeat (10) @(posedge clk);
        expect_read(32'h04, 32'h2);
        assert (irq_count - irq_before == 1)
            else report_mismatch("irq_o count", irq_count - irq_before, 1);
        assert (txn_count - txn_before == 2 * N + N * N)
            else report_mismatch("memory transactions", txn_count - txn_before, 2 * N + N * N);
        for (int i = 0; i < 256; i++) begin
            assert (mem[i] === exp_mem[i])
                else report_mismatch($sformatf("mem word 0x%h", i * 4), mem[i], exp_mem[i]);
        end
        apb_access(1'b1, 32'h04, 32'h0, rd_data, rd_err);
        expect_read(32'h04, 32'h0);
    endtask

    initial begin
        rst_n = 1'b0;
        {psel_i, penable_i, pwrite_i} = '0;
        paddr_i = '0;
        pwdata_i = '0;
        {mem_gnt_i, mem_rvalid_i} = '0;
        mem_rdata_i = '0;
        {txn_count, irq_count, cycles} = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // reset values
        expect_read(32'h04, 32'h0);
        expect_read(32'h08, 32'h0);
        expect_read(32'h0c, 32'h0);
        expect_read(32'h10, 32'h0);
        assert (!mem_req_o && !irq_o)
            else report_mismatch("{mem_req_o, irq_o}", {mem_req_o, irq_o}, 0);
        // register readback and unmapped offset
        apb_access(1'b1, 32'h08, 32'hcafe_0100, rd_data, rd_err);
        apb_access(1'b1, 32'h0c, 32'h1234_5678, rd_data, rd_err);
        apb_access(1'b1, 32'h10, 32'h0bad_f00c, rd_data, rd_err);
        expect_read(32'h08, 32'hcafe_0100);
        expect_read(32'h0c, 32'h1234_5678);
        expect_read(32'h10, 32'h0bad_f00c);
        apb_access(1'b0, 32'h14, '0, rd_data, rd_err);
        assert (rd_err) else report_mismatch("pslverr_o", rd_err, 1);
        // memory port and irq quiet until the first start
        assert (txn_count == 0) else report_mismatch("memory transactions", txn_count, 0);
        assert (irq_count == 0) else report_mismatch("irq_o count", irq_count, 0);
        load_job(32'h100, 32'h140, 32'h200, 1'b0);
        run_job(1'b0);
        load_job(32'h300, 32'h320, 32'h380, 1'b1);
        run_job(1'b1);
        if (i_dut.i_props.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// File: src.f
source/mm_pkg.sv
source/mm_apb_regs.sv
source/mm_dma_engine.sv
source/mm_systolic_array.sv
source/mm_accel_top.sv
dv/mm_accel_properties.sv
dv/mm_accel_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= mm_accel_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
